// File: source/spi_bridge_pkg.sv
`default_nettype none

package spi_bridge_pkg;

  // command bytes sent by the master
  typedef enum logic [7:0] {
    cmd_echo      = 8'h11,
    cmd_ram_write = 8'h12,
    cmd_ram_read  = 8'h13,
    cmd_gpio_dir  = 8'h14,
    cmd_gpio_data = 8'h15
  } cmd_opcode_e;

  localparam logic [7:0] ack_fill = 8'hff; // idle reply on miso

  localparam logic [7:0] ack_echo      = 8'h22;
  localparam logic [7:0] ack_ram_write = 8'h23;
  localparam logic [7:0] ack_ram_read  = 8'h24;
  localparam logic [7:0] ack_gpio_dir  = 8'h25;
  localparam logic [7:0] ack_gpio_data = 8'h26;

  typedef struct packed {
    logic [3:0] pad;  // ignored
    logic [3:0] pins;
  } gpio_nibble_t;

  // one received byte, read as opcode in idle or as pin nibble in the gpio states
  typedef union packed {
    cmd_opcode_e  opcode;
    gpio_nibble_t gpio;
    logic [7:0]   raw;
  } spi_byte_u;

  typedef enum logic [2:0] {
    op_none,
    op_ack,
    op_echo,
    op_set_addr,
    op_ram_write,
    op_ram_read,
    op_gpio_dir,
    op_gpio_data
  } exec_op_e;

  typedef struct packed {
    logic       valid; // one clk pulse
    exec_op_e   op;
    spi_byte_u  data;  // byte as received
    logic [7:0] ack;   // reply for op_ack
  } exec_req_t;

  typedef struct packed {
    logic       valid; // one clk pulse
    logic [7:0] data;  // next reply byte
  } exec_rsp_t;

endpackage

`default_nettype wire

// File: source/spi_byte_rx.sv
`timescale 1ns/10ps
`default_nettype none

module spi_byte_rx (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      select_n,
  input  logic                      mclk,
  input  logic                      mosi,
  output logic                      miso,
  input  logic [7:0]                tx_byte,
  output spi_bridge_pkg::spi_byte_u rx_byte,
  output logic                      rx_done,
  output logic                      sel
);

  logic [1:0] select_sync;
  logic [2:0] mclk_sync;   // two sync stages, third one for edge detect
  logic [1:0] mosi_sync;
  logic       mclk_rise;
  logic       mclk_fall;
  logic [2:0] bit_cnt;     // rising edges seen in this byte
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      select_sync <= 2'b11; // deselected
      mclk_sync   <= '0;
      mosi_sync   <= '0;
    end else begin
      select_sync <= {select_sync[0], select_n};
      mclk_sync   <= {mclk_sync[1:0], mclk};
      mosi_sync   <= {mosi_sync[0], mosi};
    end
  end

  assign sel       = ~select_sync[1];
  assign mclk_rise = mclk_sync[1] & ~mclk_sync[2];
  assign mclk_fall = ~mclk_sync[1] & mclk_sync[2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      if (!sel) begin
        bit_cnt <= '0;
      end else if (mclk_rise) begin
        bit_cnt <= bit_cnt + 3'd1; // wraps to 0 after the 8th bit
        rx_done <= (bit_cnt == 3'd7);
      end
    end
  end

  // msb first, mosi is stable around the rising edge
  always_ff @(posedge clk) begin
    if (sel && mclk_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};
    end
  end

  assign rx_byte.raw = rx_shift;

  // reply side, changes on falling edges so the master samples on the next rise
  always_ff @(posedge clk) begin
    if (!sel) begin
      tx_shift <= tx_byte; // msb visible before the first rising edge
    end else if (mclk_fall) begin
      if (bit_cnt == 3'd0) begin
        tx_shift <= tx_byte; // byte boundary
      end else begin
        tx_shift <= {tx_shift[6:0], 1'b1};
      end
    end
  end

  assign miso = tx_shift[7];

endmodule

`default_nettype wire

// File: source/cmd_decode.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_decode (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      sel,
  input  logic                      rx_done,
  input  spi_bridge_pkg::spi_byte_u rx_byte,
  output spi_bridge_pkg::exec_req_t exec_req,
  output logic                      err
);

  import spi_bridge_pkg::*;

  typedef enum logic [3:0] {
    st_idle,
    st_error,
    st_echo,
    st_write_addr,
    st_write_data,
    st_read_addr,
    st_read_data,
    st_gpio_dir,
    st_gpio_data
  } state_e;

  state_e    state;
  state_e    state_nx;
  exec_req_t req_nx;

  always_comb begin
    state_nx     = state;
    req_nx.valid = 1'b1;
    req_nx.op    = op_none;
    req_nx.data  = rx_byte;
    req_nx.ack   = ack_fill;
    case (state)
      st_idle: begin
        req_nx.op = op_ack; // first byte is the command
        case (rx_byte.opcode)
          cmd_echo: begin
            state_nx   = st_echo;
            req_nx.ack = ack_echo;
          end
          cmd_ram_write: begin
            state_nx   = st_write_addr;
            req_nx.ack = ack_ram_write;
          end
          cmd_ram_read: begin
            state_nx   = st_read_addr;
            req_nx.ack = ack_ram_read;
          end
          cmd_gpio_dir: begin
            state_nx   = st_gpio_dir;
            req_nx.ack = ack_gpio_dir;
          end
          cmd_gpio_data: begin
            state_nx   = st_gpio_data;
            req_nx.ack = ack_gpio_data;
          end
          default: state_nx = st_error; // acked with fill
        endcase
      end
      st_echo:       req_nx.op = op_echo;
      st_write_addr: begin
        req_nx.op = op_set_addr;
        state_nx  = st_write_data;
      end
      st_write_data: req_nx.op = op_ram_write;
      st_read_addr: begin
        req_nx.op = op_set_addr; // reply for this byte is still fill
        state_nx  = st_read_data;
      end
      st_read_data:  req_nx.op = op_ram_read;
      st_gpio_dir:   req_nx.op = op_gpio_dir;
      st_gpio_data:  req_nx.op = op_gpio_data;
      default:       req_nx.valid = 1'b0; // stuck until deselect
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      exec_req <= '0;
    end else if (!sel) begin
      state          <= st_idle;
      exec_req.valid <= 1'b0;
    end else if (rx_done) begin
      state    <= state_nx;
      exec_req <= req_nx;
    end else begin
      exec_req.valid <= 1'b0;
    end
  end

  assign err = (state == st_error);

endmodule

`default_nettype wire

// File: source/cmd_execute.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_execute #(
  parameter int ram_depth = 256
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      sel,
  input  spi_bridge_pkg::exec_req_t exec_req,
  input  logic [3:0]                gpio_in,
  output logic [3:0]                gpio_out,
  output logic [3:0]                gpio_oe,
  output spi_bridge_pkg::exec_rsp_t exec_rsp
);

  import spi_bridge_pkg::*;

  localparam int addr_w = $clog2(ram_depth);

  logic [7:0]        ram [ram_depth];
  logic [addr_w-1:0] ptr;        // wraps at ram_depth
  logic [3:0]        gpio_meta;
  logic [3:0]        gpio_sync;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_meta <= '0;
      gpio_sync <= '0;
    end else begin
      gpio_meta <= gpio_in;
      gpio_sync <= gpio_meta;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr      <= '0;
      gpio_oe  <= '0;
      gpio_out <= '0;
      exec_rsp <= '0;
    end else begin
      exec_rsp.valid <= exec_req.valid;
      if (exec_req.valid) begin
        case (exec_req.op)
          op_ack:  exec_rsp.data <= exec_req.ack;
          op_echo: exec_rsp.data <= exec_req.data.raw;
          op_set_addr: begin
            ptr           <= exec_req.data.raw[addr_w-1:0];
            exec_rsp.data <= ack_fill;
          end
          op_ram_write: begin
            ptr           <= ptr + addr_w'(1);
            exec_rsp.data <= ack_fill;
          end
          op_ram_read: begin
            ptr           <= ptr + addr_w'(1);
            exec_rsp.data <= ram[ptr];
          end
          op_gpio_dir: begin
            gpio_oe       <= exec_req.data.gpio.pins;
            exec_rsp.data <= ack_fill;
          end
          op_gpio_data: begin
            gpio_out      <= exec_req.data.gpio.pins;
            exec_rsp.data <= {4'h0, gpio_sync};
          end
          default: exec_rsp.data <= ack_fill;
        endcase
      end
      if (!sel) begin
        ptr <= '0; // next transaction starts at address 0
      end
    end
  end

  always_ff @(posedge clk) begin
    if (exec_req.valid && exec_req.op == op_ram_write) begin
      ram[ptr] <= exec_req.data.raw;
    end
  end

endmodule

`default_nettype wire

// File: source/reply_result.sv
`timescale 1ns/10ps
`default_nettype none

module reply_result (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      sel,
  input  spi_bridge_pkg::exec_rsp_t exec_rsp,
  output logic [7:0]                tx_byte
);

  import spi_bridge_pkg::*;

  // held until the receiver picks it up at the byte boundary
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_byte <= ack_fill;
    end else if (!sel) begin
      tx_byte <= ack_fill; // first byte of a transaction replies fill
    end else if (exec_rsp.valid) begin
      tx_byte <= exec_rsp.data;
    end
  end

endmodule

`default_nettype wire

// File: source/spi_bridge_top.sv
`timescale 1ns/10ps
`default_nettype none

module spi_bridge_top #(
  parameter int ram_depth = 256
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       select_n,
  input  logic       mclk,
  input  logic       mosi,
  output logic       miso,
  output logic       err,
  input  logic [3:0] gpio_in,
  output logic [3:0] gpio_out,
  output logic [3:0] gpio_oe
);

  import spi_bridge_pkg::*;

  spi_byte_u  rx_byte;
  logic       rx_done;
  logic       sel;      // synchronized, high while selected
  exec_req_t  exec_req;
  exec_rsp_t  exec_rsp;
  logic [7:0] tx_byte;

  spi_byte_rx u_rx (
    .clk      (clk),
    .arst_n   (arst_n),
    .select_n (select_n),
    .mclk     (mclk),
    .mosi     (mosi),
    .miso     (miso),
    .tx_byte  (tx_byte),
    .rx_byte  (rx_byte),
    .rx_done  (rx_done),
    .sel      (sel)
  );

  cmd_decode u_decode (
    .clk      (clk),
    .arst_n   (arst_n),
    .sel      (sel),
    .rx_done  (rx_done),
    .rx_byte  (rx_byte),
    .exec_req (exec_req),
    .err      (err)
  );

  cmd_execute #(
    .ram_depth (ram_depth)
  ) u_execute (
    .clk      (clk),
    .arst_n   (arst_n),
    .sel      (sel),
    .exec_req (exec_req),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .exec_rsp (exec_rsp)
  );

  reply_result u_result (
    .clk      (clk),
    .arst_n   (arst_n),
    .sel      (sel),
    .exec_rsp (exec_rsp),
    .tx_byte  (tx_byte)
  );

endmodule

`default_nettype wire

// File: test/tb_spi_master.svh
`ifndef tb_spi_master_svh
`define tb_spi_master_svh

// one mode 0 byte, msb first, returns the bits seen on miso
task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
  @(posedge clk);
  for (int i = 7; i >= 0; i--) begin
    mosi <= tx[i];  // mclk is low here
    repeat (half_clk - 1) @(posedge clk);
    @(negedge clk);
    rx[i] = miso;   // settled since the last falling edge
    @(posedge clk);
    mclk <= 1'b1;
    repeat (half_clk) @(posedge clk);
    mclk <= 1'b0;
  end
endtask

task automatic check_reply(input spi_bridge_pkg::spi_byte_u expected,
                           input spi_bridge_pkg::spi_byte_u actual);
  checks++;
  if (actual.raw !== expected.raw) begin
    $display("Error miso reply: expected 0x%h, got 0x%h at %0t", expected.raw, actual.raw, $time);
    errors++;
  end
endtask

task automatic check_gpio(input string name, input spi_bridge_pkg::gpio_nibble_t expected,
                          input spi_bridge_pkg::gpio_nibble_t actual);
  checks++;
  if (actual.pins !== expected.pins) begin
    $display("Error %s: expected 0x%h, got 0x%h at %0t", name, expected.pins, actual.pins, $time);
    errors++;
  end
endtask

task automatic check_err(input logic expected, input logic actual);
  checks++;
  if (actual !== expected) begin
    $display("Error err: expected 0x%h, got 0x%h at %0t", expected, actual, $time);
    errors++;
  end
endtask

// release select and wait for the bridge to drop back to idle
task automatic deselect();
  int n;
  @(posedge clk);
  select_n <= 1'b1;
  repeat (half_clk) @(posedge clk); // gap between transactions
  @(negedge clk);
  n = 0;
  while (err !== 1'b0 && n < 16) begin
    @(negedge clk);
    n++;
  end
  if (err !== 1'b0) begin
    $display("timeout: err still high long after select was released");
    errors++;
  end
  model_release();
endtask

// select, send every byte of frame with full checking, deselect
task automatic run_frame();
  spi_bridge_pkg::spi_byte_u expected;
  spi_bridge_pkg::spi_byte_u got;
  logic [7:0]                rx_raw;
  logic [7:0]                r;
  r = rand_byte();
  @(posedge clk);
  gpio_in  <= r[3:0]; // held for the whole transfer
  select_n <= 1'b0;
  foreach (frame[k]) begin
    expected.raw = model_reply; // reply to the previous byte
    spi_xfer(frame[k], rx_raw);
    got.raw = rx_raw;
    model_byte(frame[k]);
    @(negedge clk);
    check_reply(expected, got);
    check_err(model_state == ms_error, err);
    check_gpio("gpio_oe", gpio_nibble_t'({4'h0, model_oe}), gpio_nibble_t'({4'h0, gpio_oe}));
    check_gpio("gpio_out", gpio_nibble_t'({4'h0, model_out}), gpio_nibble_t'({4'h0, gpio_out}));
  end
  deselect();
endtask

`endif

// File: test/tb_spi_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spi_bridge;

  import spi_bridge_pkg::*;

  localparam int ram_depth = 256;
  localparam int half_clk  = 8;   // clk cycles per mclk half period

  typedef enum logic [3:0] {
    ms_idle, ms_error, ms_echo, ms_waddr, ms_wdata, ms_raddr, ms_rdata, ms_gdir, ms_gdata
  } model_state_e;

  logic         clk;
  logic         arst_n;
  logic         select_n;
  logic         mclk;
  logic         mosi;
  logic         miso;
  logic         err;
  logic [3:0]   gpio_in;
  logic [3:0]   gpio_out;
  logic [3:0]   gpio_oe;

  integer       seed = 32'he598;
  int           errors;
  int           checks;
  int           tests_run;
  int           tests_failed;
  logic [7:0]   frame[$];       // bytes of the next transaction

  logic [7:0]   model_ram [ram_depth];
  logic [7:0]   model_ptr;
  logic [3:0]   model_oe;
  logic [3:0]   model_out;
  logic [7:0]   model_reply;    // due during the next byte
  model_state_e model_state;

  spi_bridge_top #(
    .ram_depth (ram_depth)
  ) UUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .select_n (select_n),
    .mclk     (mclk),
    .mosi     (mosi),
    .miso     (miso),
    .err      (err),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

  always #50 clk = ~clk;

  `include "tb_spi_master.svh"

  function automatic logic [7:0] rand_byte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic logic [7:0] unknown_opcode();
    logic [7:0] b;
    b = rand_byte();
    if (b >= 8'h11 && b <= 8'h15) begin
      b = b ^ 8'h80;
    end
    return b;
  endfunction

  task automatic start_frame(input logic [7:0] cmd);
    frame.delete();
    frame.push_back(cmd);
  endtask

  task automatic add_random(input int n);
    repeat (n) frame.push_back(rand_byte());
  endtask

  task automatic add_bytes(input logic [7:0] b, input int n);
    repeat (n) frame.push_back(b);
  endtask

  task automatic model_release();
    model_state = ms_idle;
    model_ptr   = 8'h00;
    model_reply = 8'hff;
  endtask

  // bridge rules for one received byte
  task automatic model_byte(input logic [7:0] b);
    model_reply = 8'hff;
    case (model_state)
      ms_idle: begin
        case (b)
          8'h11: model_state = ms_echo;
          8'h12: model_state = ms_waddr;
          8'h13: model_state = ms_raddr;
          8'h14: model_state = ms_gdir;
          8'h15: model_state = ms_gdata;
          default: model_state = ms_error;
        endcase
        if (model_state != ms_error) begin
          model_reply = b + 8'h11; // acks run 0x22 to 0x26
        end
      end
      ms_echo: model_reply = b;
      ms_waddr, ms_raddr: begin
        model_ptr   = b;
        model_state = (model_state == ms_waddr) ? ms_wdata : ms_rdata;
      end
      ms_wdata: begin
        model_ram[model_ptr] = b;
        model_ptr = model_ptr + 8'd1;
      end
      ms_rdata: begin
        model_reply = model_ram[model_ptr];
        model_ptr = model_ptr + 8'd1;
      end
      ms_gdir: model_oe = b[3:0];
      ms_gdata: begin
        model_out   = b[3:0];
        model_reply = {4'h0, gpio_in};
      end
      default: ; // error state stays silent
    endcase
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    int         mark;
    int         len;
    logic [7:0] addr;
    logic [7:0] kind;
    clk = 1'b0;
    arst_n   <= 1'b0;
    select_n <= 1'b1;
    mclk     <= 1'b0;
    mosi     <= 1'b0;
    gpio_in  <= 4'h0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    model_oe  = 4'h0;
    model_out = 4'h0;
    model_release();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    // known contents everywhere so reads never hit unwritten bytes
    mark = errors;
    start_frame(8'h12);
    frame.push_back(8'h00);
    for (int a = 0; a < ram_depth; a++) begin
      addr = a[7:0];
      frame.push_back({addr[2:0], addr[7:3]} ^ 8'h3c);
    end
    run_frame();
    report_test("ram preload", mark);

    mark = errors;
    start_frame(8'h11);
    add_random(6);
    run_frame();
    report_test("echo", mark);

    mark = errors;
    for (int round = 0; round < 2; round++) begin
      addr = (round == 0) ? rand_byte() : (rand_byte() | 8'hf0); // second one wraps
      len  = int'(rand_byte() % 8'd16) + 1;
      if (round == 1) begin
        len = len + 16; // long enough to cross 0xff
      end
      start_frame(8'h12);
      frame.push_back(addr);
      add_random(len);
      run_frame();
      start_frame(8'h13);
      frame.push_back(addr);
      add_bytes(8'h00, len + 1);
      run_frame();
    end
    report_test("ram write and read", mark);

    mark = errors;
    start_frame(8'h14);
    add_random(3);
    run_frame();
    start_frame(8'h15);
    add_random(4);
    run_frame();
    report_test("gpio", mark);

    mark = errors;
    start_frame(unknown_opcode());
    add_random(3);
    run_frame();
    start_frame(8'h11);
    add_random(3);
    run_frame();
    report_test("unknown command", mark);

    mark = errors;
    start_frame(8'h12);
    frame.push_back(rand_byte()); // broken off after the address
    run_frame();
    addr = rand_byte();
    start_frame(8'h12);
    frame.push_back(addr);
    add_random(4);
    run_frame();
    start_frame(8'h13);
    frame.push_back(addr);
    add_bytes(8'h00, 5);
    run_frame();
    report_test("mid transaction deselect", mark);

    mark = errors;
    for (int t = 0; t < 200; t++) begin
      kind = rand_byte() % 8'd6;
      if (kind < 8'd5) begin
        start_frame(8'h11 + kind);
      end else begin
        start_frame(unknown_opcode());
      end
      add_random(int'(rand_byte() % 8'd8) + 1);
      run_frame();
    end
    report_test("random mix", mark);

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+test
source/spi_bridge_pkg.sv
source/spi_byte_rx.sv
source/cmd_decode.sv
source/cmd_execute.sv
source/reply_result.sv
source/spi_bridge_top.sv
test/tb_spi_bridge.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, log to sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -sv --timescale 1ns/10ps \
		--top-module tb_spi_bridge -f project.f -Mdir obj_dir
	./obj_dir/Vtb_spi_bridge > sim.log
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
